/* Rasterix.f */
+incdir+verification
hw/RasterixPkg.sv
hw/CommandParser.sv
hw/RegisterBank.sv
hw/Rasterizer.sv
hw/FrameBuffer.sv
hw/Rasterix.sv
verification/RasterixTb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST ?= Rasterix.f
TB_TOP ?= RasterixTb
RTL_TOP ?= Rasterix
BUILD_DIR ?= obj_dir
LOG ?= sim.log
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(wildcard hw/*.sv) $(wildcard verification/*)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/RasterixTbTasks.svh */
//////////////////////////////////////////////////
// Command stream
//////////////////////////////////////////////////

// Called on a falling edge, returns on the falling edge after the transfer
task automatic sendWord(input logic [CmdWidth-1:0] word, input logic last);
    sCmdValid = 1'b1;
    sCmdData = word;
    sCmdLast = last;
    while (!sCmdReady) begin
        @(negedge aclk);
    end
    @(negedge aclk);
    sCmdValid = 1'b0;
    sCmdLast = 1'b0;
endtask

task automatic writeConfig(input int index, input logic [CmdWidth-1:0] value);
    sendWord({OpRenderConfig, RegIndexWidth'(index), 24'h0}, 1'b0);
    sendWord(value, 1'b1);
endtask

task automatic setClearColor(input logic [FbStreamWidth-1:0] color);
    clearColor = color;
    writeConfig(RegClearColor, {16'h0, color});
endtask

task automatic setScissor(input logic enable, input int sx, input int sy,
                          input int ex, input int ey);
    scissorEnable = enable;
    windowStartX = sx;
    windowStartY = sy;
    windowEndX = ex;
    windowEndY = ey;
    writeConfig(RegFeatureEnable, CmdWidth'(enable) << FeatureScissorBit);
    writeConfig(RegScissorStart, {16'(sy), 16'(sx)});
    writeConfig(RegScissorEnd, {16'(ey), 16'(ex)});
endtask

// Start inclusive, end exclusive
function automatic logic insideWindow(input int px, input int py);
    if (!scissorEnable) begin
        return 1'b1;
    end
    return px >= windowStartX && px < windowEndX && py >= windowStartY && py < windowEndY;
endfunction

//////////////////////////////////////////////////
// Triangles and the reference image
//////////////////////////////////////////////////
task automatic setBox(input int sx, input int sy, input int ex, input int ey);
    triangleWords[TriBbStart] = {16'(sy), 16'(sx)};
    triangleWords[TriBbEnd] = {16'(ey), 16'(ex)};
endtask

task automatic setEdge(input int e, input int start, input int incX, input int incY);
    triangleWords[TriW0 + e] = start;
    triangleWords[TriW0IncX + e] = incX;
    triangleWords[TriW0IncY + e] = incY;
endtask

task automatic paintTriangle();
    int sx;
    int sy;
    int ex;
    int ey;
    int w;
    logic covered;
    sx = int'(triangleWords[TriBbStart][15:0]);
    sy = int'(triangleWords[TriBbStart][31:16]);
    ex = int'(triangleWords[TriBbEnd][15:0]);
    ey = int'(triangleWords[TriBbEnd][31:16]);
    for (int py = sy; py <= ey; py++) begin
        for (int px = sx; px <= ex; px++) begin
            covered = 1'b1;
            for (int e = 0; e < 3; e++) begin
                w = int'(triangleWords[TriW0 + e])
                    + (px - sx) * int'(triangleWords[TriW0IncX + e])
                    + (py - sy) * int'(triangleWords[TriW0IncY + e]);
                if (w < 0) begin
                    covered = 1'b0;
                end
            end
            if (covered && insideWindow(px, py)) begin
                model[py * XResolution + px] = triangleWords[TriColor][FbStreamWidth-1:0];
            end
        end
    end
endtask

task automatic drawTriangle();
    sendWord({OpTriangle, 28'h0}, 1'b0);
    for (int i = 0; i < TriangleParamCount; i++) begin
        sendWord(triangleWords[i], i == TriangleParamCount - 1);
    end
    paintTriangle();
endtask

// Waits for the whole commit stream so the image stays put while it is checked
task automatic frameBufferCommand(input logic memset, input logic commit);
    int target;
    target = commitsSeen + 1;
    sendWord({OpFramebuffer, commit, memset, 26'h0}, 1'b1);
    if (memset) begin
        for (int i = 0; i < FbSize; i++) begin
            if (insideWindow(i % XResolution, i / XResolution)) begin
                model[i] = clearColor;
            end
        end
    end
    if (commit) begin
        while (commitsSeen != target) begin
            @(negedge aclk);
        end
    end
endtask

//////////////////////////////////////////////////
// Test bookkeeping
//////////////////////////////////////////////////
task automatic beginTest();
    errorsAtStart = errorCount;
endtask

task automatic endTest(input string name);
    testCount++;
    if (errorCount == errorsAtStart) begin
        $display("[%0d] %s: pass", testCount, name);
    end else begin
        testsFailed++;
        $display("[%0d] %s: fail (%0d errors)", testCount, name, errorCount - errorsAtStart);
    end
endtask

/* verification/RasterixTb.sv */
`timescale 1ns/1ps

module RasterixTb;
    import RasterixPkg::*;

    // Six commits at half throughput, memsets and renders, then doubled
    localparam int CommitCount = 6;
    localparam int MemsetCount = 3;
    localparam int RenderCount = 4;
    localparam int CommandCycles = 400;
    localparam int CycleLimit = 2 * (2 * CommitCount * FbSize + MemsetCount * FbSize
        + RenderCount * FbSize + CommandCycles);

    logic aclk;
    logic reset;
    logic sCmdValid;
    logic sCmdReady;
    logic sCmdLast;
    logic [CmdWidth-1:0] sCmdData;
    logic mFbValid;
    logic mFbReady = 1'b0;
    logic mFbLast;
    logic [FbStreamWidth-1:0] mFbData;

    integer seed = 32'hf48be98a;
    logic [31:0] readyDraw;
    logic readyGaps;

    // Reference image and render state
    logic [FbStreamWidth-1:0] model [FbSize];
    logic [FbStreamWidth-1:0] expectedWord;
    logic [FbStreamWidth-1:0] clearColor;
    logic [FbStreamWidth-1:0] clearColors [3];
    logic [CmdWidth-1:0] triangleWords [TriangleParamCount];
    logic scissorEnable;
    int windowStartX;
    int windowStartY;
    int windowEndX;
    int windowEndY;

    logic [FbIndexWidth-1:0] beatIndex;
    logic [FbStreamWidth-1:0] heldData;
    logic heldLast;
    int commitsSeen;
    int cycleCount = 0;
    int errorCount;
    int errorsAtStart;
    int testCount;
    int testsFailed;

    `include "RasterixTbTasks.svh"

    Rasterix Rasterix_inst (
        .aclk(aclk),
        .reset(reset),
        .sCmdValid(sCmdValid),
        .sCmdReady(sCmdReady),
        .sCmdLast(sCmdLast),
        .sCmdData(sCmdData),
        .mFbValid(mFbValid),
        .mFbReady(mFbReady),
        .mFbLast(mFbLast),
        .mFbData(mFbData)
    );

    always #20 aclk = ~aclk;

    // A draw every cycle keeps the seed sequence fixed
    always @(negedge aclk) begin
        readyDraw = $random(seed);
        mFbReady = readyGaps ? readyDraw[0] : 1'b1;
    end

    always @(posedge aclk) begin
        if (reset) begin
            beatIndex <= '0;
            commitsSeen <= 0;
        end else if (mFbValid && mFbReady) begin
            beatIndex <= beatIndex + 1'b1;
            if (mFbLast) begin
                commitsSeen <= commitsSeen + 1;
            end
        end
    end

    // Stream word as seen one cycle earlier
    always @(posedge aclk) begin
        heldData <= mFbData;
        heldLast <= mFbLast;
    end

    assign expectedWord = model[beatIndex];

    //////////////////////////////////////////////////
    // Stream checks
    //////////////////////////////////////////////////
    assert property (@(posedge aclk) disable iff (reset)
        mFbValid && mFbReady |-> mFbData == expectedWord)
    else begin
        errorCount++;
        $display("Error: mFbData at pixel %0d expected 0x%04h actual 0x%04h",
            $sampled(beatIndex), $sampled(expectedWord), $sampled(mFbData));
    end

    assert property (@(posedge aclk) disable iff (reset)
        mFbValid && mFbReady |-> mFbLast == (beatIndex == FbIndexWidth'(FbSize - 1)))
    else begin
        errorCount++;
        $display("Error: mFbLast at pixel %0d expected 0x%0h actual 0x%0h",
            $sampled(beatIndex), $sampled(beatIndex == FbIndexWidth'(FbSize - 1)),
            $sampled(mFbLast));
    end

    assert property (@(posedge aclk) disable iff (reset)
        mFbValid && !mFbReady |=> $stable(mFbData))
    else begin
        errorCount++;
        $display("Error: mFbData under back-pressure expected 0x%04h actual 0x%04h",
            $sampled(heldData), $sampled(mFbData));
    end

    assert property (@(posedge aclk) disable iff (reset)
        mFbValid && !mFbReady |=> $stable(mFbLast))
    else begin
        errorCount++;
        $display("Error: mFbLast under back-pressure expected 0x%0h actual 0x%0h",
            $sampled(heldLast), $sampled(mFbLast));
    end

    assert property (@(posedge aclk) disable iff (reset)
        mFbValid && !mFbReady |=> mFbValid)
    else begin
        errorCount++;
        $display("Stream word was withdrawn before it was accepted");
    end

    always @(posedge aclk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Run stopped after %0d cycles without finishing", cycleCount);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] colorDraw;
        aclk = 1'b0;
        reset = 1'b1;
        sCmdValid = 1'b0;
        sCmdLast = 1'b0;
        sCmdData = '0;
        readyGaps = 1'b0;
        scissorEnable = 1'b0;
        errorCount = 0;
        testCount = 0;
        testsFailed = 0;
        for (int i = 0; i < 3; i++) begin
            colorDraw = $random(seed);
            clearColors[i] = colorDraw[FbStreamWidth-1:0];
        end
        repeat (2) @(negedge aclk);
        reset = 1'b0;

        beginTest();
        setScissor(1'b0, 0, 0, 0, 0);
        setClearColor(clearColors[0]);
        frameBufferCommand(1'b1, 1'b0);
        frameBufferCommand(1'b0, 1'b1);
        endTest("memset then commit");

        beginTest();
        setBox(2, 3, 12, 13);
        setEdge(0, 0, 1, 0);
        setEdge(1, 0, 0, 1);
        setEdge(2, 10, -1, -1);
        triangleWords[TriColor] = 32'h0000_f800;
        drawTriangle();
        frameBufferCommand(1'b0, 1'b1);
        endTest("triangle coverage");

        beginTest();
        setScissor(1'b1, 4, 5, 11, 10);
        setClearColor(clearColors[1]);
        frameBufferCommand(1'b1, 1'b1);
        setBox(0, 0, 15, 15);
        setEdge(0, -4, 1, 1);
        setEdge(1, 20, -1, -1);
        setEdge(2, 12, -1, 1);
        triangleWords[TriColor] = 32'h0000_07e0;
        drawTriangle();
        frameBufferCommand(1'b0, 1'b1);
        endTest("scissor window");

        beginTest();
        readyGaps = 1'b1;
        setScissor(1'b0, 0, 0, 0, 0);
        setBox(1, 0, 14, 9);
        setEdge(0, -2, 0, 1);
        setEdge(1, 13, -1, 0);
        setEdge(2, 6, 1, -1);
        triangleWords[TriColor] = 32'h0000_001f;
        drawTriangle();
        frameBufferCommand(1'b0, 1'b1);
        endTest("stream back-pressure");

        beginTest();
        setClearColor(clearColors[2]);
        setBox(0, 0, 15, 15);
        setEdge(0, 0, 1, 0);
        setEdge(1, 0, 0, 1);
        setEdge(2, 15, -1, -1);
        triangleWords[TriColor] = 32'h0000_ffe0;
        // Memset header goes out while the render still holds the parser
        drawTriangle();
        frameBufferCommand(1'b1, 1'b0);
        frameBufferCommand(1'b0, 1'b1);
        endTest("command order");

        $display("Summary: %0d tests, %0d failed, %0d errors", testCount, testsFailed,
            errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* hw/Rasterix.sv */
`timescale 1ns/1ps

module Rasterix (
    input  logic aclk,
    input  logic reset,

    input  logic sCmdValid,
    output logic sCmdReady,
    input  logic sCmdLast,
    input  logic [RasterixPkg::CmdWidth-1:0] sCmdData,

    output logic mFbValid,
    input  logic mFbReady,
    output logic mFbLast,
    output logic [RasterixPkg::FbStreamWidth-1:0] mFbData
);
    import RasterixPkg::*;

    regWrite_t configWrite;
    regWrite_t triangleWrite;
    fbCommand_t fbCmd;
    fragment_t fragment;
    renderConfig_t renderConfig;
    logic startRendering;
    logic rasterizerRunning;
    logic applied;
    logic [CmdWidth-1:0] configRegs [ConfigRegCount];
    logic [CmdWidth-1:0] triangleParams [TriangleParamCount];

    //////////////////////////////////////////////////
    // Configuration decode
    //////////////////////////////////////////////////
    assign renderConfig.scissorEnable = configRegs[RegFeatureEnable][FeatureScissorBit];
    assign renderConfig.scissorStartX = configRegs[RegScissorStart][0 +: ScreenPosWidth];
    assign renderConfig.scissorStartY =
        configRegs[RegScissorStart][CmdWidth / 2 +: ScreenPosWidth];
    assign renderConfig.scissorEndX = configRegs[RegScissorEnd][0 +: ScreenPosWidth];
    assign renderConfig.scissorEndY = configRegs[RegScissorEnd][CmdWidth / 2 +: ScreenPosWidth];
    assign renderConfig.clearColor = configRegs[RegClearColor][FbStreamWidth-1:0];

    CommandParser commandParser (
        .aclk(aclk),
        .reset(reset),
        .sCmdValid(sCmdValid),
        .sCmdReady(sCmdReady),
        .sCmdLast(sCmdLast),
        .sCmdData(sCmdData),
        .configWrite(configWrite),
        .triangleWrite(triangleWrite),
        .startRendering(startRendering),
        .rasterizerRunning(rasterizerRunning),
        .fbCmd(fbCmd),
        .applied(applied)
    );

    RegisterBank #(.BankSize(ConfigRegCount)) configBank (
        .aclk(aclk),
        .reset(reset),
        .write(configWrite),
        .registers(configRegs)
    );

    RegisterBank #(.BankSize(TriangleParamCount)) triangleBank (
        .aclk(aclk),
        .reset(reset),
        .write(triangleWrite),
        .registers(triangleParams)
    );

    Rasterizer rasterizer (
        .aclk(aclk),
        .reset(reset),
        .startRendering(startRendering),
        .rasterizerRunning(rasterizerRunning),
        .triangleParams(triangleParams),
        .fragment(fragment)
    );

    FrameBuffer colorBuffer (
        .aclk(aclk),
        .reset(reset),
        .renderConfig(renderConfig),
        .fragment(fragment),
        .fbCmd(fbCmd),
        .applied(applied),
        .mFbValid(mFbValid),
        .mFbReady(mFbReady),
        .mFbLast(mFbLast),
        .mFbData(mFbData)
    );

endmodule

/* hw/FrameBuffer.sv */
`timescale 1ns/1ps

module FrameBuffer (
    input  logic aclk,
    input  logic reset,

    input  RasterixPkg::renderConfig_t renderConfig,
    input  RasterixPkg::fragment_t fragment,

    input  RasterixPkg::fbCommand_t fbCmd,
    output logic applied,

    output logic mFbValid,
    input  logic mFbReady,
    output logic mFbLast,
    output logic [RasterixPkg::FbStreamWidth-1:0] mFbData
);
    import RasterixPkg::*;

    logic [FbStreamWidth-1:0] mem [FbSize];
    logic [FbIndexWidth-1:0] index;
    logic memsetActive;
    logic commitLoading;
    logic commitPending;
    logic atLastPixel;
    logic writeEnable;
    logic [FbIndexWidth-1:0] writeIndex;
    logic [FbStreamWidth-1:0] writeColor;

    // Start inclusive, end exclusive
    function automatic logic inScissor(input logic [ScreenPosWidth-1:0] px,
                                       input logic [ScreenPosWidth-1:0] py);
        return !renderConfig.scissorEnable
            || (px >= renderConfig.scissorStartX && px < renderConfig.scissorEndX
                && py >= renderConfig.scissorStartY && py < renderConfig.scissorEndY);
    endfunction

    assign atLastPixel = index == FbIndexWidth'(FbSize - 1);

    //////////////////////////////////////////////////
    // Write port, shared by memset and fragments
    //////////////////////////////////////////////////
    always_comb begin
        if (memsetActive) begin
            writeEnable = inScissor(index[0 +: ScreenPosWidth],
                                    index[ScreenPosWidth +: ScreenPosWidth]);
            writeIndex = index;
            writeColor = renderConfig.clearColor;
        end else begin
            writeEnable = fragment.valid && inScissor(fragment.x, fragment.y);
            writeIndex = {fragment.y, fragment.x};
            writeColor = fragment.color;
        end
    end

    always_ff @(posedge aclk) begin
        if (writeEnable) begin
            mem[writeIndex] <= writeColor;
        end
    end

    //////////////////////////////////////////////////
    // Command sequencing and commit stream
    //////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (reset) begin
            index <= '0;
            memsetActive <= 1'b0;
            commitLoading <= 1'b0;
            commitPending <= 1'b0;
            applied <= 1'b0;
            mFbValid <= 1'b0;
            mFbLast <= 1'b0;
        end else begin
            applied <= 1'b0;

            if (fbCmd.apply) begin
                index <= '0;
                memsetActive <= fbCmd.memset;
                commitLoading <= fbCmd.commit && !fbCmd.memset;
                commitPending <= fbCmd.commit && fbCmd.memset;
                applied <= !fbCmd.memset && !fbCmd.commit;
            end

            if (memsetActive) begin
                index <= index + 1'b1;
                if (atLastPixel) begin
                    // Index wraps to zero, ready for a following commit
                    memsetActive <= 1'b0;
                    commitLoading <= commitPending;
                    commitPending <= 1'b0;
                    applied <= !commitPending;
                end
            end

            // Output register only moves when empty or accepted
            if (mFbReady || !mFbValid) begin
                mFbValid <= commitLoading;
                mFbLast <= commitLoading && atLastPixel;
                if (commitLoading) begin
                    mFbData <= mem[index];
                    index <= index + 1'b1;
                    if (atLastPixel) begin
                        commitLoading <= 1'b0;
                    end
                end
            end

            if (mFbValid && mFbReady && mFbLast) begin
                applied <= 1'b1;
            end
        end
    end

    // Parser holds off commands, so renders never overlap buffer commands
    assert property (@(posedge aclk) disable iff (reset)
        fragment.valid |-> !(memsetActive || commitLoading || mFbValid));

endmodule

/* hw/Rasterizer.sv */
`timescale 1ns/1ps

module Rasterizer (
    input  logic aclk,
    input  logic reset,

    input  logic startRendering,
    output logic rasterizerRunning,

    input  logic [RasterixPkg::CmdWidth-1:0] triangleParams [RasterixPkg::TriangleParamCount],

    output RasterixPkg::fragment_t fragment
);
    import RasterixPkg::*;

    logic [ScreenPosWidth-1:0] x;
    logic [ScreenPosWidth-1:0] y;
    logic [ScreenPosWidth-1:0] bbStartX;
    logic [ScreenPosWidth-1:0] bbStartY;
    logic [ScreenPosWidth-1:0] bbEndX;
    logic [ScreenPosWidth-1:0] bbEndY;
    logic [CmdWidth-1:0] w [EdgeCount];
    logic [CmdWidth-1:0] wRow [EdgeCount];
    logic covered;

    // x in the low half-word, y in the high half-word
    assign bbStartX = triangleParams[TriBbStart][0 +: ScreenPosWidth];
    assign bbStartY = triangleParams[TriBbStart][CmdWidth / 2 +: ScreenPosWidth];
    assign bbEndX = triangleParams[TriBbEnd][0 +: ScreenPosWidth];
    assign bbEndY = triangleParams[TriBbEnd][CmdWidth / 2 +: ScreenPosWidth];

    // Inside when no edge value is negative
    always_comb begin
        covered = 1'b1;
        for (int i = 0; i < EdgeCount; i++) begin
            covered = covered && !w[i][CmdWidth-1];
        end
    end

    assign fragment.valid = rasterizerRunning && covered;
    assign fragment.x = x;
    assign fragment.y = y;
    assign fragment.color = triangleParams[TriColor][FbStreamWidth-1:0];

    always_ff @(posedge aclk) begin
        if (reset) begin
            rasterizerRunning <= 1'b0;
        end else if (startRendering) begin
            rasterizerRunning <= 1'b1;
        end else if (rasterizerRunning && x == bbEndX && y == bbEndY) begin
            rasterizerRunning <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Bounding box walk
    //////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (startRendering) begin
            x <= bbStartX;
            y <= bbStartY;
            for (int i = 0; i < EdgeCount; i++) begin
                w[i] <= triangleParams[TriW0 + i];
                wRow[i] <= triangleParams[TriW0 + i];
            end
        end else if (rasterizerRunning) begin
            if (x == bbEndX) begin
                // Next row starts from the stepped row start
                x <= bbStartX;
                y <= y + 1'b1;
                for (int i = 0; i < EdgeCount; i++) begin
                    wRow[i] <= wRow[i] + triangleParams[TriW0IncY + i];
                    w[i] <= wRow[i] + triangleParams[TriW0IncY + i];
                end
            end else begin
                x <= x + 1'b1;
                for (int i = 0; i < EdgeCount; i++) begin
                    w[i] <= w[i] + triangleParams[TriW0IncX + i];
                end
            end
        end
    end

endmodule

/* hw/RegisterBank.sv */
`timescale 1ns/1ps

module RegisterBank #(
    parameter int BankSize = 4
) (
    input  logic aclk,
    input  logic reset,
    input  RasterixPkg::regWrite_t write,
    output logic [RasterixPkg::CmdWidth-1:0] registers [BankSize]
);
    import RasterixPkg::*;

    logic [RegIndexWidth-1:0] index;

    always_ff @(posedge aclk) begin
        if (reset) begin
            index <= '0;
        end else if (write.start) begin
            index <= write.startIndex;
        end else if (write.valid) begin
            index <= index + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        for (int i = 0; i < BankSize; i++) begin
            if (reset) begin
                registers[i] <= '0;
            end else if (write.valid && index == RegIndexWidth'(i)) begin
                registers[i] <= write.data;
            end
        end
    end

    // Parser never sends more words than the bank holds
    assert property (@(posedge aclk) disable iff (reset)
        write.valid |-> index < BankSize);

endmodule

/* hw/CommandParser.sv */
`timescale 1ns/1ps

module CommandParser (
    input  logic aclk,
    input  logic reset,

    input  logic sCmdValid,
    output logic sCmdReady,
    input  logic sCmdLast,
    input  logic [RasterixPkg::CmdWidth-1:0] sCmdData,

    output RasterixPkg::regWrite_t configWrite,
    output RasterixPkg::regWrite_t triangleWrite,

    output logic startRendering,
    input  logic rasterizerRunning,

    output RasterixPkg::fbCommand_t fbCmd,
    input  logic applied
);
    import RasterixPkg::*;

    cmdHeader_t header;
    logic [ParserStateWidth-1:0] state;
    logic [RegIndexWidth-1:0] wordCount;
    logic accept;

    assign header = sCmdData;
    assign accept = sCmdValid && sCmdReady;

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= ParserIdle;
            sCmdReady <= 1'b0;
            wordCount <= '0;
            configWrite.start <= 1'b0;
            configWrite.valid <= 1'b0;
            triangleWrite.start <= 1'b0;
            triangleWrite.valid <= 1'b0;
            startRendering <= 1'b0;
            fbCmd.apply <= 1'b0;
        end else begin
            configWrite.start <= 1'b0;
            configWrite.valid <= 1'b0;
            triangleWrite.start <= 1'b0;
            triangleWrite.valid <= 1'b0;
            startRendering <= 1'b0;
            fbCmd.apply <= 1'b0;

            case (state)
                ParserIdle: begin
                    sCmdReady <= 1'b1;
                    if (accept) begin
                        case (header.configHeader.opcode)
                            OpRenderConfig: begin
                                configWrite.start <= 1'b1;
                                configWrite.startIndex <= header.configHeader.regIndex;
                                state <= ParserConfigData;
                            end
                            OpTriangle: begin
                                triangleWrite.start <= 1'b1;
                                triangleWrite.startIndex <= '0;
                                wordCount <= '0;
                                state <= ParserTriangleLoad;
                            end
                            OpFramebuffer: begin
                                fbCmd.apply <= 1'b1;
                                fbCmd.commit <= header.fbHeader.commit;
                                fbCmd.memset <= header.fbHeader.memset;
                                sCmdReady <= 1'b0;
                                state <= ParserFbWait;
                            end
                            default: begin
                                // OpNop and unknown opcodes are dropped
                            end
                        endcase
                    end
                end
                ParserConfigData: begin
                    if (accept) begin
                        configWrite.valid <= 1'b1;
                        configWrite.data <= sCmdData;
                        state <= ParserIdle;
                    end
                end
                ParserTriangleLoad: begin
                    if (accept) begin
                        triangleWrite.valid <= 1'b1;
                        triangleWrite.data <= sCmdData;
                        wordCount <= wordCount + 1'b1;
                        if (wordCount == RegIndexWidth'(TriangleParamCount - 1)) begin
                            sCmdReady <= 1'b0;
                            state <= ParserRenderWait;
                        end else if (sCmdLast) begin
                            // Packet ended early, no render
                            state <= ParserIdle;
                        end
                    end
                end
                ParserRenderWait: begin
                    // Start once the last word has landed in the bank
                    if (triangleWrite.valid) begin
                        startRendering <= 1'b1;
                    end else if (!startRendering && !rasterizerRunning) begin
                        sCmdReady <= 1'b1;
                        state <= ParserIdle;
                    end
                end
                ParserFbWait: begin
                    if (applied) begin
                        sCmdReady <= 1'b1;
                        state <= ParserIdle;
                    end
                end
                default: begin
                    state <= ParserIdle;
                end
            endcase
        end
    end

    // A new render may only start after the previous walk has ended
    assert property (@(posedge aclk) disable iff (reset)
        $rose(startRendering) |-> !rasterizerRunning);

endmodule

/* hw/RasterixPkg.sv */
package RasterixPkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////
    localparam int CmdWidth = 32;
    localparam int FbStreamWidth = 16;
    localparam int XResolution = 16;
    localparam int YResolution = 16;
    localparam int ScreenPosWidth = $clog2(XResolution);
    localparam int FbSize = XResolution * YResolution;
    localparam int FbIndexWidth = $clog2(FbSize);
    localparam int OpcodeWidth = 4;
    localparam int RegIndexWidth = 4;
    localparam int EdgeCount = 3;

    // Opcodes in the top nibble of a header word
    localparam logic [OpcodeWidth-1:0] OpNop = 4'h0;
    localparam logic [OpcodeWidth-1:0] OpRenderConfig = 4'h2;
    localparam logic [OpcodeWidth-1:0] OpFramebuffer = 4'h3;
    localparam logic [OpcodeWidth-1:0] OpTriangle = 4'h4;

    // Render configuration registers
    localparam int RegFeatureEnable = 0;
    localparam int RegClearColor = 1;
    localparam int RegScissorStart = 2;
    localparam int RegScissorEnd = 3;
    localparam int ConfigRegCount = 4;
    localparam int FeatureScissorBit = 0;

    // Triangle words, in stream order
    localparam int TriBbStart = 0;
    localparam int TriBbEnd = 1;
    localparam int TriW0 = 2;
    localparam int TriW1 = 3;
    localparam int TriW2 = 4;
    localparam int TriW0IncX = 5;
    localparam int TriW1IncX = 6;
    localparam int TriW2IncX = 7;
    localparam int TriW0IncY = 8;
    localparam int TriW1IncY = 9;
    localparam int TriW2IncY = 10;
    localparam int TriColor = 11;
    localparam int TriangleParamCount = 12;

    // Command parser states
    localparam int ParserStateWidth = 3;
    localparam logic [ParserStateWidth-1:0] ParserIdle = 3'd0;
    localparam logic [ParserStateWidth-1:0] ParserConfigData = 3'd1;
    localparam logic [ParserStateWidth-1:0] ParserTriangleLoad = 3'd2;
    localparam logic [ParserStateWidth-1:0] ParserRenderWait = 3'd3;
    localparam logic [ParserStateWidth-1:0] ParserFbWait = 3'd4;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [OpcodeWidth-1:0] opcode;
        logic [RegIndexWidth-1:0] regIndex;
        logic [CmdWidth-OpcodeWidth-RegIndexWidth-1:0] reserved;
    } configHeader_t;

    typedef struct packed {
        logic [OpcodeWidth-1:0] opcode;
        logic commit;
        logic memset;
        logic [CmdWidth-OpcodeWidth-3:0] reserved;
    } fbHeader_t;

    typedef union packed {
        configHeader_t configHeader;
        fbHeader_t fbHeader;
    } cmdHeader_t;

    typedef struct packed {
        logic start;
        logic [RegIndexWidth-1:0] startIndex;
        logic valid;
        logic [CmdWidth-1:0] data;
    } regWrite_t;

    typedef struct packed {
        logic valid;
        logic [ScreenPosWidth-1:0] x;
        logic [ScreenPosWidth-1:0] y;
        logic [FbStreamWidth-1:0] color;
    } fragment_t;

    typedef struct packed {
        logic apply;
        logic commit;
        logic memset;
    } fbCommand_t;

    typedef struct packed {
        logic scissorEnable;
        logic [ScreenPosWidth-1:0] scissorStartX;
        logic [ScreenPosWidth-1:0] scissorStartY;
        logic [ScreenPosWidth-1:0] scissorEndX;
        logic [ScreenPosWidth-1:0] scissorEndY;
        logic [FbStreamWidth-1:0] clearColor;
    } renderConfig_t;

endpackage
